// ==== tb.f ====
+incdir+src
src/video_timing_pkg.sv
src/pixel_pkg.sv
src/checker_writer.sv
src/frame_buffer.sv
src/vga_timing.sv
src/vga_pixel_out.sv
src/vga_frame_top.sv
bench/tb_vga_frame.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_vga_frame -f tb.f -o vga_frame_sim &&
	./obj_dir/vga_frame_sim | tee /dev/stderr | grep -q "All checks passed" &&
	echo "Simulation PASSED" ||
	{ echo "Simulation FAILED"; exit 1; }

// ==== bench/tb_vga_frame.sv ====
`include "vga_defs.svh"

module tb_vga_frame
	import pixel_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	////////////////////////////////////////////////////////////
	// Scan lengths and run limits
	////////////////////////////////////////////////////////////
	localparam int CLK_HALF = 4;
	localparam int LINE_CYCLES = `VGA_H_ACTIVE + `VGA_H_FRONT + `VGA_H_PULSE + `VGA_H_BACK;
	localparam int FRAME_LINES = `VGA_V_ACTIVE + `VGA_V_FRONT + `VGA_V_PULSE + `VGA_V_BACK;
	localparam int FRAME_CYCLES = LINE_CYCLES * FRAME_LINES;
	localparam int FRAMES_TO_RUN = 2;
	// Sync fall to first pixel, last pixel to frame sync
	localparam int HS_TO_ACTIVE = `VGA_H_PULSE + `VGA_H_BACK;
	localparam int ACTIVE_TO_VS = `VGA_H_FRONT + `VGA_H_PULSE + `VGA_H_BACK +
		`VGA_V_FRONT * LINE_CYCLES;
	// Two frames plus 10 percent
	localparam int WATCHDOG_CYCLES = FRAMES_TO_RUN * FRAME_CYCLES * 11 / 10;

	logic      M10k_pll = 1'b0;
	logic      reset;
	channel8_t vga_r;
	channel8_t vga_g;
	channel8_t vga_b;
	logic      vga_hs;
	logic      vga_vs;
	logic      vga_blank_n;

	// Lines that get a full pixel check, one entry per line
	bit chosen_line [$];
	int n_chosen = 0;
	int pix_checked = 0;

	// Tracker state, sampled on the falling edge
	logic        p_hs = 1'b1;
	logic        p_vs = 1'b1;
	logic        p_bn = 1'b0;
	logic        s_bn = 1'b0;
	logic [23:0] s_rgb = '0;
	bit          sampled = 1'b0;
	bit          ev_hs_fall, ev_hs_rise, ev_vs_fall, ev_vs_rise, ev_bn_rise, ev_bn_fall;
	bit          seen_hs = 1'b0;
	bit          seen_vs = 1'b0;
	bit          line_ok, frame_ok;
	int          hs_period = 0;
	int          hs_low = 0;
	int          vs_period = 0;
	int          vs_low = 0;
	int          run_len = 0;
	int          rises_in_line = 0;
	int          since_bn_fall = 0;
	int          px_x = 0;
	int          px_y = -1;
	// Measured lengths, latched at the edge that ends them
	int          m_line, m_hs_low, m_frame, m_vs_low, m_run, m_lines;
	// Sync placement against active video
	int          m_hs_to_bn;
	int          m_bn_to_vs;
	int          vs_rises = 0;
	bit          done = 1'b0;

	always #CLK_HALF M10k_pll = ~M10k_pll;

	vga_frame_top i_dut (
		.M10k_pll    (M10k_pll),
		.reset       (reset),
		.vga_r       (vga_r),
		.vga_g       (vga_g),
		.vga_b       (vga_b),
		.vga_hs      (vga_hs),
		.vga_vs      (vga_vs),
		.vga_blank_n (vga_blank_n)
	);

	////////////////////////////////////////////////////////////
	// Reference model and error reports
	////////////////////////////////////////////////////////////

	// RGB332 fields into channel MSBs, zeros below
	function automatic logic [23:0] expand_rgb332(input logic [7:0] c);
		expand_rgb332 = {c[7:5], 5'b0, c[4:2], 5'b0, c[1:0], 6'b0};
	endfunction

	function automatic logic [23:0] expected_pixel(input int x, input int y);
		logic [7:0] c;
		if (x == `BORDER_X_LO || x == `BORDER_X_HI || y == `BORDER_Y_LO || y == `BORDER_Y_HI)
			c = `COLOR_BORDER;
		else if (y < `FB_HEIGHT / 2)
			c = (x < `FB_WIDTH / 2) ? `COLOR_TOP_LEFT : `COLOR_TOP_RIGHT;
		else
			c = (x < `FB_WIDTH / 2) ? `COLOR_BOTTOM_LEFT : `COLOR_BOTTOM_RIGHT;
		expected_pixel = expand_rgb332(c);
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
		$display("Checks failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic report_failure(input string what);
		$display("Error: %s", what);
		$display("Checks failed");
		$fatal(1, "run stopped at first error");
	endtask

	// Idle pin levels of reset
	task automatic check_idle();
		assert (vga_hs === 1'b1 && vga_vs === 1'b1 && vga_blank_n === 1'b0)
		else report_mismatch("{vga_hs,vga_vs,vga_blank_n} in reset",
			32'({vga_hs, vga_vs, vga_blank_n}), 32'h6);
		assert ({vga_r, vga_g, vga_b} === 24'h0)
		else report_mismatch("{vga_r,vga_g,vga_b} in reset", 32'({vga_r, vga_g, vga_b}), 0);
	endtask

	////////////////////////////////////////////////////////////
	// Tracker, edges and positions from the output pins
	////////////////////////////////////////////////////////////
	always @(negedge M10k_pll) begin
		if (!reset) begin
			ev_hs_fall = p_hs && !vga_hs;
			ev_hs_rise = !p_hs && vga_hs;
			ev_vs_fall = p_vs && !vga_vs;
			ev_vs_rise = !p_vs && vga_vs;
			ev_bn_rise = !p_bn && vga_blank_n;
			ev_bn_fall = p_bn && !vga_blank_n;
			// Line period, fall to fall
			line_ok = ev_hs_fall && seen_hs;
			if (ev_hs_fall) begin
				m_line = hs_period;
				hs_period = 1;
				seen_hs = 1'b1;
				rises_in_line = 0;
			end else begin
				hs_period++;
			end
			if (ev_hs_fall)
				hs_low = 1;
			else if (!vga_hs)
				hs_low++;
			if (ev_hs_rise)
				m_hs_low = hs_low;
			// Clocks since the last active pixel
			if (ev_bn_fall)
				since_bn_fall = 0;
			else
				since_bn_fall++;
			// Frame period, same scheme in clocks
			frame_ok = ev_vs_fall && seen_vs;
			if (ev_vs_fall) begin
				m_frame = vs_period;
				vs_period = 1;
				seen_vs = 1'b1;
				m_lines = px_y + 1;
				m_bn_to_vs = since_bn_fall;
				px_y = -1;
			end else begin
				vs_period++;
			end
			if (ev_vs_fall)
				vs_low = 1;
			else if (!vga_vs)
				vs_low++;
			if (ev_vs_rise)
				m_vs_low = vs_low;
			// Active pixel position
			if (ev_bn_rise) begin
				// Clocks from the sync fall to the first pixel
				m_hs_to_bn = hs_period - 1;
				px_y++;
				px_x = 0;
				run_len = 1;
				rises_in_line++;
			end else if (vga_blank_n) begin
				px_x++;
				run_len++;
			end
			if (ev_bn_fall)
				m_run = run_len;
			s_bn = vga_blank_n;
			s_rgb = {vga_r, vga_g, vga_b};
			p_hs = vga_hs;
			p_vs = vga_vs;
			p_bn = vga_blank_n;
			sampled = 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Comparison against the reference
	////////////////////////////////////////////////////////////
	always @(posedge M10k_pll) begin
		if (sampled && !done) begin
			if (!s_bn)
				assert (s_rgb == 24'h0)
				else report_mismatch("{vga_r,vga_g,vga_b} while blanked", 32'(s_rgb), 0);
			if (s_bn) begin
				assert (px_y >= 0 && px_y < `FB_HEIGHT)
				else report_failure("vga_blank_n high outside the 480 active lines");
				if (chosen_line[px_y]) begin
					assert (s_rgb == expected_pixel(px_x, px_y))
					else report_mismatch($sformatf("{vga_r,vga_g,vga_b} at x %0d y %0d",
						px_x, px_y), 32'(s_rgb), 32'(expected_pixel(px_x, px_y)));
					pix_checked++;
				end
				// Overlay on every line, independent of the chosen set
				if (px_x == `BORDER_X_LO || px_x == `BORDER_X_HI ||
					px_y == `BORDER_Y_LO || px_y == `BORDER_Y_HI)
					assert (s_rgb == expand_rgb332(`COLOR_BORDER))
					else report_mismatch($sformatf("border pixel at x %0d y %0d", px_x, px_y),
						32'(s_rgb), 32'(expand_rgb332(`COLOR_BORDER)));
			end
			if (line_ok)
				assert (m_line == LINE_CYCLES)
				else report_mismatch("vga_hs line period", m_line, LINE_CYCLES);
			if (ev_hs_rise)
				assert (m_hs_low == `VGA_H_PULSE)
				else report_mismatch("vga_hs low time", m_hs_low, `VGA_H_PULSE);
			if (frame_ok)
				assert (m_frame == FRAME_CYCLES)
				else report_mismatch("vga_vs frame period", m_frame, FRAME_CYCLES);
			if (ev_vs_fall)
				assert (m_lines == `VGA_V_ACTIVE)
				else report_mismatch("vga_blank_n active lines per frame", m_lines, `VGA_V_ACTIVE);
			if (ev_vs_fall)
				assert (m_bn_to_vs == ACTIVE_TO_VS)
				else report_mismatch("vga_blank_n fall to vga_vs fall", m_bn_to_vs, ACTIVE_TO_VS);
			if (ev_bn_fall)
				assert (m_run == `VGA_H_ACTIVE)
				else report_mismatch("vga_blank_n active run", m_run, `VGA_H_ACTIVE);
			if (ev_bn_rise)
				assert (rises_in_line == 1)
				else report_failure("vga_blank_n rose more than once within one line");
			if (ev_bn_rise && seen_hs)
				assert (m_hs_to_bn == HS_TO_ACTIVE)
				else report_mismatch("vga_hs fall to vga_blank_n rise", m_hs_to_bn, HS_TO_ACTIVE);
			if (ev_vs_rise) begin
				assert (m_vs_low == `VGA_V_PULSE * LINE_CYCLES)
				else report_mismatch("vga_vs low time", m_vs_low, `VGA_V_PULSE * LINE_CYCLES);
				vs_rises++;
				if (vs_rises == FRAMES_TO_RUN)
					done = 1'b1;
			end
		end
	end

	// Watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge M10k_pll);
		report_failure("timeout, two frames did not complete");
	end

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////
	initial begin
		reset = 1'b1;
		void'($urandom(69047));
		// Fixed lines plus roughly one in six at random
		for (int y = 0; y < `FB_HEIGHT; y++) begin
			chosen_line.push_back(y == 0 || y == `BORDER_Y_LO || y == `FB_HEIGHT / 2 - 1 ||
				y == `FB_HEIGHT / 2 || y == `BORDER_Y_HI || y == `FB_HEIGHT - 1 ||
				($urandom % 6) == 0);
			if (chosen_line[y])
				n_chosen++;
		end
		// Three clocks of reset, idle pins throughout
		repeat (2) begin
			@(posedge M10k_pll);
			@(negedge M10k_pll);
			check_idle();
		end
		@(posedge M10k_pll);
		#1 reset = 1'b0;
		// Release cycle and the one after it still idle
		repeat (2) begin
			@(negedge M10k_pll);
			check_idle();
		end
		wait (done);
		assert (pix_checked == FRAMES_TO_RUN * n_chosen * `FB_WIDTH)
		else report_mismatch("checked pixel count", pix_checked,
			FRAMES_TO_RUN * n_chosen * `FB_WIDTH);
		$display("All checks passed");
		$finish;
	end

endmodule

// ==== src/vga_frame_top.sv ====
module vga_frame_top
	import video_timing_pkg::*;
	import pixel_pkg::*;
(
	input  logic      M10k_pll,
	input  logic      reset,
	output channel8_t vga_r,
	output channel8_t vga_g,
	output channel8_t vga_b,
	output logic      vga_hs,
	output logic      vga_vs,
	output logic      vga_blank_n
);

	// Writer to memory
	logic         wr_en;
	fb_addr_t     wr_addr;
	rgb332_t      wr_data;

	// Timing to memory and output stage
	fb_addr_t     rd_addr;
	rgb332_t      rd_data;
	pixel_coord_t scan_x;
	pixel_coord_t scan_y;
	logic         active_d;
	logic         hsync_d;
	logic         vsync_d;

	////////////////////////////////////////////////////////////
	// Write side
	////////////////////////////////////////////////////////////
	checker_writer i_writer (
		.M10k_pll (M10k_pll),
		.reset    (reset),
		.wr_en    (wr_en),
		.wr_addr  (wr_addr),
		.wr_data  (wr_data)
	);

	frame_buffer i_frame_buffer (
		.M10k_pll (M10k_pll),
		.wr_en    (wr_en),
		.wr_addr  (wr_addr),
		.wr_data  (wr_data),
		.rd_addr  (rd_addr),
		.rd_data  (rd_data)
	);

	////////////////////////////////////////////////////////////
	// Display side
	////////////////////////////////////////////////////////////
	vga_timing i_timing (
		.M10k_pll (M10k_pll),
		.reset    (reset),
		.rd_addr  (rd_addr),
		.scan_x   (scan_x),
		.scan_y   (scan_y),
		.active_d (active_d),
		.hsync_d  (hsync_d),
		.vsync_d  (vsync_d)
	);

	vga_pixel_out i_pixel_out (
		.M10k_pll    (M10k_pll),
		.reset       (reset),
		.rd_data     (rd_data),
		.scan_x      (scan_x),
		.scan_y      (scan_y),
		.active_d    (active_d),
		.hsync_d     (hsync_d),
		.vsync_d     (vsync_d),
		.vga_r       (vga_r),
		.vga_g       (vga_g),
		.vga_b       (vga_b),
		.vga_hs      (vga_hs),
		.vga_vs      (vga_vs),
		.vga_blank_n (vga_blank_n)
	);

endmodule

// ==== src/vga_pixel_out.sv ====
`include "vga_defs.svh"

module vga_pixel_out
	import video_timing_pkg::*;
	import pixel_pkg::*;
(
	input  logic         M10k_pll,
	input  logic         reset,
	input  rgb332_t      rd_data,
	input  pixel_coord_t scan_x,
	input  pixel_coord_t scan_y,
	input  logic         active_d,
	input  logic         hsync_d,
	input  logic         vsync_d,
	output channel8_t    vga_r,
	output channel8_t    vga_g,
	output channel8_t    vga_b,
	output logic         vga_hs,
	output logic         vga_vs,
	output logic         vga_blank_n
);

	// Coordinates of the word now on rd_data
	pixel_coord_t x_d;
	pixel_coord_t y_d;
	logic         on_border;
	rgb332_t      shown;

	always_ff @(posedge M10k_pll) begin
		x_d <= scan_x;
		y_d <= scan_y;
	end

	////////////////////////////////////////////////////////////
	// Border overlay
	////////////////////////////////////////////////////////////
	assign on_border = (x_d == pixel_coord_t'(`BORDER_X_LO)) ||
		(x_d == pixel_coord_t'(`BORDER_X_HI)) ||
		(y_d == pixel_coord_t'(`BORDER_Y_LO)) ||
		(y_d == pixel_coord_t'(`BORDER_Y_HI));
	assign shown = on_border ? rgb332_t'(`COLOR_BORDER) : rd_data;

	////////////////////////////////////////////////////////////
	// Output registers
	////////////////////////////////////////////////////////////
	always_ff @(posedge M10k_pll) begin
		if (reset) begin
			vga_r       <= '0;
			vga_g       <= '0;
			vga_b       <= '0;
			vga_hs      <= 1'b1;
			vga_vs      <= 1'b1;
			vga_blank_n <= 1'b0;
		end else begin
			vga_hs      <= hsync_d;
			vga_vs      <= vsync_d;
			vga_blank_n <= active_d;
			// Fields into the channel MSBs, black while blanked
			vga_r <= active_d ? {shown.red, 5'b0} : '0;
			vga_g <= active_d ? {shown.green, 5'b0} : '0;
			vga_b <= active_d ? {shown.blue, 6'b0} : '0;
		end
	end

endmodule

// ==== src/vga_timing.sv ====
`include "vga_defs.svh"

module vga_timing
	import video_timing_pkg::*;
(
	input  logic         M10k_pll,
	input  logic         reset,
	output fb_addr_t     rd_addr,
	output pixel_coord_t scan_x,
	output pixel_coord_t scan_y,
	output logic         active_d,
	output logic         hsync_d,
	output logic         vsync_d
);

	// Phase machines and their position counters
	scan_phase_t  h_phase;
	scan_phase_t  v_phase;
	pixel_coord_t h_count;
	pixel_coord_t v_count;

	// Final count of the current phase
	pixel_coord_t h_last;
	pixel_coord_t v_last;
	logic         h_end;
	logic         v_end;

	// One clock pulse in the last back porch clock of a line
	logic line_done;

	// Undelayed level flags
	logic active;
	logic hsync;
	logic vsync;

	function automatic scan_phase_t next_phase(input scan_phase_t p);
		case (p)
			phase_active: next_phase = phase_front;
			phase_front:  next_phase = phase_pulse;
			phase_pulse:  next_phase = phase_back;
			default:      next_phase = phase_active;
		endcase
	endfunction

	////////////////////////////////////////////////////////////
	// Phase lengths
	////////////////////////////////////////////////////////////
	always_comb begin
		case (h_phase)
			phase_active: h_last = pixel_coord_t'(`VGA_H_ACTIVE - 1);
			phase_front:  h_last = pixel_coord_t'(`VGA_H_FRONT - 1);
			phase_pulse:  h_last = pixel_coord_t'(`VGA_H_PULSE - 1);
			default:      h_last = pixel_coord_t'(`VGA_H_BACK - 1);
		endcase
	end

	always_comb begin
		case (v_phase)
			phase_active: v_last = pixel_coord_t'(`VGA_V_ACTIVE - 1);
			phase_front:  v_last = pixel_coord_t'(`VGA_V_FRONT - 1);
			phase_pulse:  v_last = pixel_coord_t'(`VGA_V_PULSE - 1);
			default:      v_last = pixel_coord_t'(`VGA_V_BACK - 1);
		endcase
	end

	assign h_end = (h_count == h_last);
	assign v_end = (v_count == v_last);

	////////////////////////////////////////////////////////////
	// Horizontal machine
	////////////////////////////////////////////////////////////
	// Reset parks the scan two clocks before the frame start
	// Gives the writer a head start on pixel 0
	always_ff @(posedge M10k_pll) begin
		if (reset) begin
			h_phase   <= phase_back;
			h_count   <= pixel_coord_t'(`VGA_H_BACK - 2);
			line_done <= 1'b0;
		end else begin
			if (h_end) begin
				h_count <= '0;
				h_phase <= next_phase(h_phase);
			end else begin
				h_count <= h_count + 1'b1;
			end
			// Raised one clock early so the vertical step lands on the line start
			line_done <= (h_phase == phase_back) &&
				(h_count == pixel_coord_t'(`VGA_H_BACK - 2));
		end
	end

	////////////////////////////////////////////////////////////
	// Vertical machine, steps once per line
	////////////////////////////////////////////////////////////
	always_ff @(posedge M10k_pll) begin
		if (reset) begin
			v_phase <= phase_back;
			v_count <= pixel_coord_t'(`VGA_V_BACK - 1);
		end else if (line_done) begin
			if (v_end) begin
				v_count <= '0;
				v_phase <= next_phase(v_phase);
			end else begin
				v_count <= v_count + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Read coordinates and flags
	////////////////////////////////////////////////////////////
	assign active = (h_phase == phase_active) && (v_phase == phase_active);
	assign hsync  = (h_phase != phase_pulse);
	assign vsync  = (v_phase != phase_pulse);

	// Zero outside the visible area
	assign scan_x  = active ? h_count : '0;
	assign scan_y  = active ? v_count : '0;
	assign rd_addr = fb_addr_t'(scan_y) * fb_addr_t'(`FB_WIDTH) + fb_addr_t'(scan_x);

	// Delay to match the read latency of the frame buffer
	always_ff @(posedge M10k_pll) begin
		if (reset) begin
			active_d <= 1'b0;
			hsync_d  <= 1'b1;
			vsync_d  <= 1'b1;
		end else begin
			active_d <= active;
			hsync_d  <= hsync;
			vsync_d  <= vsync;
		end
	end

	// Counters stay inside their phase
	h_count_bound: assert property (@(posedge M10k_pll) disable iff (reset)
		h_count <= h_last);
	v_count_bound: assert property (@(posedge M10k_pll) disable iff (reset)
		v_count <= v_last);

	// Line pulse is followed by the first clock of a new line
	line_start: assert property (@(posedge M10k_pll) disable iff (reset)
		line_done |=> (h_phase == phase_active && h_count == '0 && !line_done));

endmodule

// ==== src/frame_buffer.sv ====
`include "vga_defs.svh"

module frame_buffer
	import video_timing_pkg::*;
	import pixel_pkg::*;
(
	input  logic     M10k_pll,
	input  logic     wr_en,
	input  fb_addr_t wr_addr,
	input  rgb332_t  wr_data,
	input  fb_addr_t rd_addr,
	output rgb332_t  rd_data
);

	////////////////////////////////////////////////////////////
	// Pixel storage, one word per screen pixel
	////////////////////////////////////////////////////////////
	rgb332_t mem [0:`FB_DEPTH-1];

	// Write port
	always_ff @(posedge M10k_pll) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// Read port, data one clock after address
	// Same address as a write in that clock returns the old word
	always_ff @(posedge M10k_pll) begin
		rd_data <= mem[rd_addr];
	end

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	// Writer must stay inside the array
	wr_addr_in_range: assert property (@(posedge M10k_pll)
		wr_en |-> (wr_addr < fb_addr_t'(`FB_DEPTH)));

	// Reads likewise, but only inside the visible frame
	rd_addr_in_range: assert property (@(posedge M10k_pll)
		rd_addr < fb_addr_t'(`FB_DEPTH));

endmodule

// ==== src/checker_writer.sv ====
`include "vga_defs.svh"

module checker_writer
	import video_timing_pkg::*;
	import pixel_pkg::*;
(
	input  logic     M10k_pll,
	input  logic     reset,
	output logic     wr_en,
	output fb_addr_t wr_addr,
	output rgb332_t  wr_data
);

	// Raster position of the pixel being generated
	pixel_coord_t col;
	pixel_coord_t row;
	// Linear index, tracks row * width + col
	fb_addr_t     pix_idx;

	logic    last_col;
	logic    last_row;
	logic    left_half;
	logic    top_half;
	rgb332_t quad_color;

	////////////////////////////////////////////////////////////
	// Position decode
	////////////////////////////////////////////////////////////
	assign last_col  = (col == pixel_coord_t'(`FB_WIDTH - 1));
	assign last_row  = (row == pixel_coord_t'(`FB_HEIGHT - 1));
	assign left_half = (col < pixel_coord_t'(`FB_WIDTH / 2));
	assign top_half  = (row < pixel_coord_t'(`FB_HEIGHT / 2));

	// Quadrant colour lookup
	always_comb begin
		case ({left_half, top_half})
			2'b11:   quad_color = rgb332_t'(`COLOR_TOP_LEFT);
			2'b10:   quad_color = rgb332_t'(`COLOR_BOTTOM_LEFT);
			2'b01:   quad_color = rgb332_t'(`COLOR_TOP_RIGHT);
			default: quad_color = rgb332_t'(`COLOR_BOTTOM_RIGHT);
		endcase
	end

	////////////////////////////////////////////////////////////
	// Raster counters, one pixel per clock, forever
	////////////////////////////////////////////////////////////
	always_ff @(posedge M10k_pll) begin
		if (reset) begin
			col     <= '0;
			row     <= '0;
			pix_idx <= '0;
			wr_en   <= 1'b0;
		end else begin
			wr_en   <= 1'b1;
			col     <= last_col ? '0 : col + 1'b1;
			// Row steps at end of each line
			if (last_col)
				row <= last_row ? '0 : row + 1'b1;
			// Back to the first pixel after the last one
			pix_idx <= (last_col && last_row) ? '0 : pix_idx + 1'b1;
		end
	end

	// Write port registers
	always_ff @(posedge M10k_pll) begin
		wr_addr <= pix_idx;
		wr_data <= quad_color;
	end

	// Row never leaves the frame
	row_in_frame: assert property (@(posedge M10k_pll) disable iff (reset)
		row < pixel_coord_t'(`FB_HEIGHT));

	// Write after the final pixel starts the next frame at zero
	frame_wraps: assert property (@(posedge M10k_pll) disable iff (reset)
		(wr_en && wr_addr == fb_addr_t'(`FB_DEPTH - 1)) |=> (wr_addr == '0));

endmodule

// ==== src/pixel_pkg.sv ====
package pixel_pkg;

	////////////////////////////////////////////////////////////
	// Pixel formats
	////////////////////////////////////////////////////////////

	// Stored pixel, one byte per pixel
	// Red in the top bits, blue in the bottom two
	typedef struct packed {
		logic [2:0] red;
		logic [2:0] green;
		logic [1:0] blue;
	} rgb332_t;

	// One DAC channel at the pins
	typedef logic [7:0] channel8_t;

	// Expansion puts each field in the channel MSBs
	// Zero fill below

endpackage

// ==== src/video_timing_pkg.sv ====
package video_timing_pkg;

	////////////////////////////////////////////////////////////
	// Scan geometry types
	////////////////////////////////////////////////////////////

	// Screen coordinate, wide enough for 799
	typedef logic [9:0] pixel_coord_t;

	// Linear frame buffer index, row * width + column
	typedef logic [18:0] fb_addr_t;

	////////////////////////////////////////////////////////////
	// Scan phases
	////////////////////////////////////////////////////////////

	// Same order for both axes
	// Visible pixels first, then the blanking interval
	typedef enum logic [1:0] {
		phase_active = 2'd0,
		phase_front  = 2'd1,
		phase_pulse  = 2'd2,
		phase_back   = 2'd3
	} scan_phase_t;

	// Sync is driven low only in phase_pulse

endpackage

// ==== src/vga_defs.svh ====
`ifndef VGA_DEFS_SVH
`define VGA_DEFS_SVH

////////////////////////////////////////////////////////////
// Horizontal scan, lengths in pixel clocks
////////////////////////////////////////////////////////////
`define VGA_H_ACTIVE 640
`define VGA_H_FRONT 16
`define VGA_H_PULSE 96
`define VGA_H_BACK 48

////////////////////////////////////////////////////////////
// Vertical scan, lengths in lines
////////////////////////////////////////////////////////////
`define VGA_V_ACTIVE 480
`define VGA_V_FRONT 10
`define VGA_V_PULSE 2
`define VGA_V_BACK 33

// Frame buffer geometry
`define FB_WIDTH 640
`define FB_HEIGHT 480
`define FB_DEPTH (`FB_WIDTH * `FB_HEIGHT)

// White overlay lines
`define BORDER_X_LO 100
`define BORDER_X_HI 540
`define BORDER_Y_LO 100
`define BORDER_Y_HI 380

// Quadrant colours, RGB332
`define COLOR_TOP_LEFT 8'hE0
`define COLOR_BOTTOM_LEFT 8'h1C
`define COLOR_TOP_RIGHT 8'h03
`define COLOR_BOTTOM_RIGHT 8'hFC
`define COLOR_BORDER 8'hFF

`endif
